//--- if_cfg.svh
/*
 * Instruction fetch configuration
 * Address width, debug entry points, boot offset and fetch buffer depth.
 */

`ifndef IF_CFG_SVH
`define IF_CFG_SVH

// address and instruction word width
`define IF_ADDR_W       32

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR  32'h1A11_0808

// low byte of the boot entry inside the 256-byte boot region
`define IF_BOOT_OFFSET  8'h80

`define IF_FIFO_DEPTH   2 // fetch buffer entries

`endif

//--- if_pkg.sv
/*
 * Instruction fetch package
 * PC source and exception vector encodings, address and instruction types.
 */

`include "if_cfg.svh"

package if_pkg;

  typedef logic [`IF_ADDR_W-1:0] addr_t;  // byte address
  typedef logic [`IF_ADDR_W-1:0] instr_t; // instruction word

  // fetch address source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_IRQ_X   = 3'd2,
    EXC_PC_DBD     = 3'd3,
    EXC_PC_DBG_EXC = 3'd4
  } exc_pc_sel_e;

  // msb set for interrupts, low 5 bits hold the interrupt id
  typedef logic [5:0] exc_cause_t;

endpackage

//--- if_pc_sel.sv
/*
 * Next-PC selection
 * Picks the fetch address on a redirect and builds the exception vector.
 */

`timescale 1ns/1ps
`include "if_cfg.svh"

module if_pc_sel (
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::exc_cause_t  exc_cause_i,
  input  logic                pc_set_i,
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  if_pkg::addr_t       csr_mtvecx_i,
  output if_pkg::addr_t       fetch_addr_n_o,
  output logic                csr_mtvec_init_o
);
  import if_pkg::*;

  addr_t      exc_pc;
  logic [4:0] irq_id;

  assign irq_id = exc_cause_i[4:0]; // msb only tells irq from exception

  // vectored interrupts land at base + 4 * id
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_id, 2'b00};
      EXC_PC_IRQ_X:   exc_pc = {csr_mtvecx_i[31:8], 1'b0, irq_id, 2'b00};
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = {boot_addr_i[31:8], `IF_BOOT_OFFSET};
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      PC_ERET: fetch_addr_n_o = csr_mepc_i;  // back from trap handler
      PC_DRET: fetch_addr_n_o = csr_depc_i;  // back from debug mode
      default: fetch_addr_n_o = {boot_addr_i[31:8], `IF_BOOT_OFFSET};
    endcase
  end

  // mtvec takes its reset value from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  //////////////////////////////
  // checks on the redirect
  //////////////////////////////

  always_comb begin
    if (pc_set_i) begin
      assert (pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET})
        else $error("illegal pc_mux_i on redirect");
      assert (pc_mux_i != PC_BOOT || boot_addr_i[7:0] == 8'h00)
        else $error("boot address not aligned to 256 bytes");
    end
  end

endmodule

//--- if_fetch_unit.sv
/*
 * Instruction fetch unit
 * Request/grant/rvalid bus master with one request in flight, a small
 * circular buffer of fetched words and a flush on redirect.
 */

`timescale 1ns/1ps
`include "if_cfg.svh"

module if_fetch_unit (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  input  logic          branch_i,
  input  if_pkg::addr_t branch_addr_i,
  input  logic          ready_i,
  output logic          instr_req_o,
  output if_pkg::addr_t instr_addr_o,
  input  logic          instr_gnt_i,
  input  logic          instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  input  logic          instr_err_i,
  output logic          valid_o,
  output if_pkg::instr_t rdata_o,
  output if_pkg::addr_t addr_o,
  output logic          err_o,
  output logic          busy_o
);
  import if_pkg::*;

  localparam int unsigned fifo_depth = `IF_FIFO_DEPTH;
  localparam int unsigned ptr_w      = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int unsigned cnt_w      = $clog2(fifo_depth + 1);

  addr_t            fetch_addr_q, fetch_addr_d; // next sequential address
  addr_t            next_addr;
  addr_t            req_addr_q;                 // address of the live transaction
  logic             req_q, req_d;
  logic             outstanding_q, outstanding_d;
  logic             stale_q, stale_d;           // response of live txn gets dropped
  logic             hold, txn_done, live_d, raise;
  logic             push, pop;
  logic [cnt_w-1:0] count_q, count_d;
  logic [ptr_w-1:0] rd_ptr_q, wr_ptr_q;

  addr_t            addr_mem [fifo_depth];
  instr_t           data_mem [fifo_depth];
  logic             err_mem  [fifo_depth];

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // bus side
  //////////////////////////////

  assign hold      = req_q & ~instr_gnt_i;           // raised but not yet granted
  assign txn_done  = outstanding_q & instr_rvalid_i;
  assign live_d    = (req_q | outstanding_q) & ~txn_done;
  assign next_addr = branch_i ? {branch_addr_i[31:2], 2'b00} : fetch_addr_q;

  assign push = txn_done & ~stale_q & ~branch_i;
  assign pop  = valid_o & ready_i;

  always_comb begin
    if (branch_i) begin
      count_d = '0;                                  // flush on redirect
    end else begin
      count_d = count_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  // a new request needs an idle bus and room for its response
  assign raise = req_i & ~live_d & (count_d < cnt_w'(fifo_depth));

  assign req_d         = hold | raise;
  assign outstanding_d = (req_q & instr_gnt_i) | (outstanding_q & ~instr_rvalid_i);

  always_comb begin
    if (raise) begin
      stale_d = 1'b0;
    end else if (branch_i) begin
      stale_d = live_d;                              // old transaction still in flight
    end else begin
      stale_d = stale_q & live_d;
    end
  end

  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (raise) begin
      fetch_addr_d = next_addr + addr_t'(4);
    end else if (branch_i) begin
      fetch_addr_d = {branch_addr_i[31:2], 2'b00};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
      fetch_addr_q  <= '0;
    end else begin
      req_q         <= req_d;
      outstanding_q <= outstanding_d;
      stale_q       <= stale_d;
      fetch_addr_q  <= fetch_addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (raise) begin
      req_addr_q <= next_addr;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | outstanding_q;

  //////////////////////////////
  // fetch buffer
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      count_q <= count_d;
      if (branch_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
      end else begin
        if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
    end
  end

  // response address is still held in req_addr_q when rvalid arrives
  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= req_addr_q;
      data_mem[wr_ptr_q] <= instr_rdata_i;
      err_mem[wr_ptr_q]  <= instr_err_i;
    end
  end

  assign valid_o = (count_q != '0);
  assign rdata_o = data_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];

  //////////////////////////////
  // bus protocol checks
  //////////////////////////////

  a_err_with_rvalid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_err_i |-> instr_rvalid_i);

  a_req_addr_ok : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (!$isunknown(instr_addr_o) && instr_addr_o[1:0] == 2'b00));

  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)));

endmodule

//--- if_id_reg.sv
/*
 * IF-ID pipeline register
 * Valid and new flags plus the instruction, error and PC handed to decode.
 */

`timescale 1ns/1ps

module if_id_reg (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           fetch_valid_i,
  input  logic           id_in_ready_i,
  input  logic           pc_set_i,
  input  logic           instr_valid_clear_i,
  input  if_pkg::instr_t instr_i,
  input  logic           err_i,
  input  if_pkg::addr_t  pc_i,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output if_pkg::instr_t instr_rdata_id_o,
  output if_pkg::instr_t instr_rdata_alu_id_o,
  output logic           instr_fetch_err_o,
  output if_pkg::addr_t  pc_id_o
);
  import if_pkg::*;

  logic   accept;
  logic   valid_d, valid_q;
  logic   new_q;
  instr_t instr_q, instr_alu_q;
  addr_t  pc_q;
  logic   err_q;

  assign accept = fetch_valid_i & id_in_ready_i; // same as the buffer pop

  // an instruction taken in with a redirect is squashed
  assign valid_d = (accept & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= accept;   // one pulse per accepted word
    end
  end

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_q     <= instr_i;
      instr_alu_q <= instr_i; // second copy keeps alu fan-out local
      err_q       <= err_i;
      pc_q        <= pc_i;
    end
  end

  assign instr_valid_id_o     = valid_q;
  assign instr_new_id_o       = new_q;
  assign instr_rdata_id_o     = instr_q;
  assign instr_rdata_alu_id_o = instr_alu_q;
  assign instr_fetch_err_o    = err_q;
  assign pc_id_o              = pc_q;

endmodule

//--- if_pc_check.sv
/*
 * Sequential PC check
 * Alerts when the fetched PC does not follow the decode PC by one word.
 */

`timescale 1ns/1ps
`include "if_cfg.svh"

module if_pc_check (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  accept_i,
  input  logic                  branch_i,
  input  logic                  fetch_valid_i,
  input  logic [`IF_ADDR_W-1:0] pc_if_i,
  input  logic [`IF_ADDR_W-1:0] pc_id_i,
  output logic                  pc_mismatch_alert_o
);

  logic                  seq_q, seq_d;
  logic [`IF_ADDR_W-1:0] pc_id_incr;

  // no check right after reset or any redirect
  assign seq_d = (seq_q | accept_i) & ~branch_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_id_incr = pc_id_i + `IF_ADDR_W'(4);

  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (pc_if_i != pc_id_incr);

endmodule

//--- if_stage.sv
/*
 * Instruction fetch stage
 * Next-PC selection, bus fetch with buffering, IF-ID register and PC check.
 */

`timescale 1ns/1ps

module if_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  if_pkg::addr_t       boot_addr_i,
  input  logic                req_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  // to decode
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::instr_t      instr_rdata_id_o,
  output if_pkg::instr_t      instr_rdata_alu_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_if_o,
  output if_pkg::addr_t       pc_id_o,
  // control from the core
  input  logic                instr_valid_clear_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::exc_cause_t  exc_cause_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  if_pkg::addr_t       csr_mtvecx_i,
  output logic                csr_mtvec_init_o,
  input  logic                id_in_ready_i,
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);
  import if_pkg::*;

  addr_t  fetch_addr_n;
  logic   fetch_valid;
  instr_t fetch_rdata;
  addr_t  fetch_addr;
  logic   fetch_err;
  logic   accept;

  assign accept  = fetch_valid & id_in_ready_i;
  assign pc_if_o = fetch_addr;

  if_pc_sel u_pc_sel (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mtvecx_i     (csr_mtvecx_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_fetch_unit u_fetch_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .ready_i        (id_in_ready_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (fetch_addr),
    .err_o          (fetch_err),
    .busy_o         (if_busy_o)
  );

  if_id_reg u_id_reg (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .fetch_valid_i        (fetch_valid),
    .id_in_ready_i        (id_in_ready_i),
    .pc_set_i             (pc_set_i),
    .instr_valid_clear_i  (instr_valid_clear_i),
    .instr_i              (fetch_rdata),
    .err_i                (fetch_err),
    .pc_i                 (fetch_addr),
    .instr_valid_id_o     (instr_valid_id_o),
    .instr_new_id_o       (instr_new_id_o),
    .instr_rdata_id_o     (instr_rdata_id_o),
    .instr_rdata_alu_id_o (instr_rdata_alu_id_o),
    .instr_fetch_err_o    (instr_fetch_err_o),
    .pc_id_o              (pc_id_o)
  );

  if_pc_check u_pc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .accept_i            (accept),
    .branch_i            (pc_set_i),
    .fetch_valid_i       (fetch_valid),
    .pc_if_i             (fetch_addr),
    .pc_id_i             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

//--- tb_if_mem.sv
/*
 * Instruction memory model
 * Answers fetch requests with random grant and rvalid delays; data is a
 * hash of the address, and words at low byte 0xF0 come back with an error.
 */

`timescale 1ns/1ps

module tb_if_mem (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  if_pkg::addr_t  addr_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output if_pkg::instr_t rdata_o,
  output logic           err_o
);
  import if_pkg::*;

  addr_t addr_q; // address of the granted request

  // every bit of the address feeds the word
  function automatic instr_t word_at(input addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      rvalid_o = 1'b0;  // one-cycle response pulse
      err_o    = 1'b0;
      if (rst_ni && req_i) begin
        repeat ($urandom % 3) begin
          @(posedge clk_i);
          #1;
        end
        addr_q = addr_i;
        gnt_o  = 1'b1;
        @(posedge clk_i); // request accepted here
        #1;
        gnt_o = 1'b0;
        repeat ($urandom % 3) begin
          @(posedge clk_i);
          #1;
        end
        rvalid_o = 1'b1;
        rdata_o  = word_at(addr_q);
        err_o    = (addr_q[7:0] == 8'hF0);
      end
    end
  end

endmodule

//--- tb_if_stage.sv
/*
 * Fetch stage testbench
 * Boots, runs sequential and redirected fetches under back-pressure and
 * checks every new ID instruction against a next-PC reference.
 */

`timescale 1ns/1ps
`include "if_cfg.svh"

module tb_if_stage;
  import if_pkg::*;

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned N_SEQ      = 40;
  localparam int unsigned N_JUMP     = 12;
  localparam int unsigned N_RET      = 8;
  localparam int unsigned N_EXC      = 6;
  localparam int unsigned N_EXPECTED = N_SEQ + N_JUMP + 2 * N_RET + 5 * N_EXC;
  localparam int unsigned WD_CYCLES  = N_EXPECTED * 200;

  logic        clk_i, rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  addr_t       boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i;
  addr_t       csr_mtvec_i, csr_mtvecx_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;

  logic        instr_req, instr_gnt, instr_rvalid, instr_err;
  addr_t       instr_addr;
  instr_t      instr_rdata;
  logic        instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  instr_t      instr_rdata_id_o, instr_rdata_alu_id_o;
  addr_t       pc_if_o, pc_id_o;
  logic        csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o;

  addr_t       exp_pc;     // PC of the next new instruction
  addr_t       last_pc;
  instr_t      last_instr;
  addr_t       prev_pc_if; // pc_if_o one cycle back
  bit          exp_mtvec_init;
  bit          bus_pending; // granted request still waiting for rvalid
  bit          seen_any;
  int unsigned n_new;
  int unsigned n_err_seen;

  if_stage UUT (
    .clk_i, .rst_ni, .boot_addr_i, .req_i,
    .instr_req_o (instr_req), .instr_addr_o (instr_addr), .instr_gnt_i (instr_gnt),
    .instr_rvalid_i (instr_rvalid), .instr_rdata_i (instr_rdata), .instr_err_i (instr_err),
    .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o, .instr_rdata_alu_id_o,
    .instr_fetch_err_o, .pc_if_o, .pc_id_o, .instr_valid_clear_i, .pc_set_i,
    .pc_mux_i, .exc_pc_mux_i, .exc_cause_i, .branch_target_i, .csr_mepc_i,
    .csr_depc_i, .csr_mtvec_i, .csr_mtvecx_i, .csr_mtvec_init_o, .id_in_ready_i,
    .pc_mismatch_alert_o, .if_busy_o
  );

  tb_if_mem u_mem (
    .clk_i, .rst_ni, .req_i (instr_req), .addr_i (instr_addr), .gnt_o (instr_gnt),
    .rvalid_o (instr_rvalid), .rdata_o (instr_rdata), .err_o (instr_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // memory contents as the model fills them
  function automatic instr_t expected_word(input addr_t a);
    return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic addr_t ref_fetch_addr(input pc_sel_e sel, input exc_pc_sel_e exc_sel,
                                           input exc_cause_t cause);
    addr_t irq_off;
    irq_off = addr_t'(cause[4:0]) * 32'd4; // interrupt id times 4
    case (sel)
      PC_BOOT: return (boot_addr_i & 32'hFFFF_FF00) | {24'h0, `IF_BOOT_OFFSET};
      PC_JUMP: return branch_target_i;
      PC_ERET: return csr_mepc_i;
      PC_DRET: return csr_depc_i;
      PC_EXC: begin
        case (exc_sel)
          EXC_PC_EXC:     return csr_mtvec_i & 32'hFFFF_FF00;
          EXC_PC_IRQ:     return (csr_mtvec_i & 32'hFFFF_FF00) + irq_off;
          EXC_PC_IRQ_X:   return (csr_mtvecx_i & 32'hFFFF_FF00) + irq_off;
          EXC_PC_DBD:     return `IF_DM_HALT_ADDR;
          EXC_PC_DBG_EXC: return `IF_DM_EXC_ADDR;
          default:        return '0;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  task automatic stop_on_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "mismatch");
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_instr(input string what, input instr_t got, input instr_t exp);
    if (got !== exp) stop_on_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input bit exp);
    if (got !== exp) stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  //////////////////////////////
  // compare process
  //////////////////////////////

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_flag("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
      check_flag("csr_mtvec_init_o", csr_mtvec_init_o, exp_mtvec_init);
      check_flag("if_busy_o", if_busy_o, instr_req || bus_pending);
      if (instr_new_id_o) begin
        check_flag("instr_valid_id_o", instr_valid_id_o, 1'b1);
        check_addr("pc_if_o at accept", prev_pc_if, exp_pc);
        check_addr("pc_id_o", pc_id_o, exp_pc);
        check_instr("instr_rdata_id_o", instr_rdata_id_o, expected_word(exp_pc));
        check_instr("instr_rdata_alu_id_o", instr_rdata_alu_id_o, expected_word(exp_pc));
        check_flag("instr_fetch_err_o", instr_fetch_err_o, exp_pc[7:0] == 8'hF0);
        if (exp_pc[7:0] == 8'hF0) n_err_seen++;
        last_pc    = pc_id_o;
        last_instr = instr_rdata_id_o;
        seen_any   = 1'b1;
        exp_pc     = exp_pc + 32'd4;
        n_new++;
      end else if (seen_any) begin
        check_addr("held pc_id_o", pc_id_o, last_pc);
        check_instr("held instr_rdata_id_o", instr_rdata_id_o, last_instr);
        check_instr("held instr_rdata_alu_id_o", instr_rdata_alu_id_o, last_instr);
      end
      // bus state seen by the coming edge
      bus_pending = (instr_req && instr_gnt) || (bus_pending && !instr_rvalid);
      prev_pc_if  = pc_if_o;
      // the redirect takes effect at the coming edge
      if (pc_set_i) exp_pc = ref_fetch_addr(pc_mux_i, exc_pc_mux_i, exc_cause_i) & 32'hFFFF_FFFC;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // no instruction is taken in the redirect cycle
  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc_sel,
                          input exc_cause_t cause);
    pc_mux_i       = sel;
    exc_pc_mux_i   = exc_sel;
    exc_cause_i    = cause;
    pc_set_i       = 1'b1;
    exp_mtvec_init = (sel == PC_BOOT);
    id_in_ready_i  = 1'b0;
    @(posedge clk_i);
    #1;
    pc_set_i       = 1'b0;
    exp_mtvec_init = 1'b0;
  endtask

  task automatic run_instrs(input int unsigned count, input bit random_ready);
    int unsigned target;
    target = n_new + count;
    while (n_new < target) begin
      @(posedge clk_i);
      #1;
      id_in_ready_i = random_ready ? ($urandom % 4 != 0) : 1'b1;
    end
  endtask

  initial begin
    exc_cause_t cause;
    void'($urandom(33));
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    id_in_ready_i = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = '0;
    boot_addr_i = 32'h0000_1000;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    csr_mtvec_i = '0;
    csr_mtvecx_i = '0;
    exp_pc = '0;
    last_pc = '0;
    last_instr = '0;
    prev_pc_if = '0;
    exp_mtvec_init = 1'b0;
    bus_pending = 1'b0;
    seen_any = 1'b0;
    n_new = 0;
    n_err_seen = 0;

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("instr_req_o after reset", instr_req, 1'b0);
    check_flag("instr_valid_id_o after reset", instr_valid_id_o, 1'b0);
    check_flag("instr_new_id_o after reset", instr_new_id_o, 1'b0);

    @(posedge clk_i);
    #1;
    req_i = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, '0);
    run_instrs(N_SEQ, 1'b0);  // passes the error word at 0x10F0

    // valid clear with decode stalled
    @(negedge clk_i);
    check_flag("instr_valid_id_o before clear", instr_valid_id_o, 1'b1);
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b1;
    id_in_ready_i = 1'b0;
    @(posedge clk_i);
    #1;
    instr_valid_clear_i = 1'b0;
    @(negedge clk_i);
    check_flag("instr_valid_id_o after clear", instr_valid_id_o, 1'b0);
    @(posedge clk_i);
    #1;

    branch_target_i = (addr_t'($urandom) & 32'hFFFF_FF00) | 32'h0000_00E0;
    redirect(PC_JUMP, EXC_PC_EXC, '0);
    run_instrs(N_JUMP, 1'b1);
    csr_mepc_i = addr_t'($urandom) & 32'hFFFF_FFFC;
    redirect(PC_ERET, EXC_PC_EXC, '0);
    run_instrs(N_RET, 1'b1);
    csr_depc_i = addr_t'($urandom) & 32'hFFFF_FFFC;
    redirect(PC_DRET, EXC_PC_EXC, '0);
    run_instrs(N_RET, 1'b1);

    for (int i = 0; i < 5; i++) begin
      csr_mtvec_i  = addr_t'($urandom);
      csr_mtvecx_i = addr_t'($urandom);
      cause = {1'b1, 5'($urandom % 32)};
      redirect(PC_EXC, exc_pc_sel_e'(i), cause);
      run_instrs(N_EXC, 1'b1);
    end

    if (n_err_seen == 0) begin
      $display("no fetch with a bus error reached decode");
      $display("TESTBENCH FAILED");
      $fatal(1, "bus error path not exercised");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles, %0d instructions seen",
             WD_CYCLES, n_new);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verilog.f
+incdir+.
if_pkg.sv
if_pc_sel.sv
if_fetch_unit.sv
if_id_reg.sv
if_pc_check.sv
if_stage.sv
tb_if_mem.sv
tb_if_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_if_stage --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi
exit 0
